// File: Bender.yml
package:
  name: mm_acq

sources:
  - src/adc_stream_pkg.sv
  - src/acq_ctrl_pkg.sv
  - src/exec_controller.sv
  - src/baseline_calib.sv
  - src/mm_trigger.sv
  - src/event_framer.sv
  - src/stream_fifo.sv
  - src/mm_acq_top.sv
  - target: test
    files:
      - dv/mm_acq_props.sv
      - dv/mm_acq_tb.sv

// File: dv/mm_acq_props.sv
`default_nettype none

module mm_acq_props
    import adc_stream_pkg::*;
    import acq_ctrl_pkg::*;
(
    input wire                  AXIS_ACLK,
    input wire                  AXIS_ARESETN,
    input wire tdata_t          m_axis_tdata,
    input wire                  m_axis_tvalid,
    input wire                  m_axis_tlast,
    input wire                  m_axis_tready,
    input wire exec_state_t     exec_state,
    input wire                  start_trg,
    input wire                  wr_en,
    input wire [FIFO_CNT_W-1:0] fifo_free
);

    // a stalled beat stays put until it is taken
    hold_under_stall: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        m_axis_tvalid && !m_axis_tready |=>
            m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
    else
        $error("output beat changed while stalled");

    // RUN is only entered from CALIB
    run_after_calib: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        exec_state == RUN && $past(exec_state) != RUN |-> $past(exec_state) == CALIB)
    else
        $error("RUN entered without calibration");

    // the trigger pipeline only carries beats presented in RUN
    trigger_only_in_run: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        start_trg |-> exec_state == RUN && $past(exec_state) == RUN
            && $past(exec_state, 2) == RUN)
    else
        $error("start_trg high without a RUN beat behind it");

    no_write_when_full: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        fifo_free == '0 |-> !wr_en)
    else
        $error("FIFO written while full");

endmodule

bind mm_acq_top mm_acq_props i_props (
    .AXIS_ACLK     (AXIS_ACLK),
    .AXIS_ARESETN  (AXIS_ARESETN),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tready (m_axis_tready),
    .exec_state    (exec_state),
    .start_trg     (start_trg),
    .wr_en         (wr_en),
    .fifo_free     (fifo_free)
);

`default_nettype wire

// File: dv/mm_acq_tb.sv
`default_nettype none

module mm_acq_tb
    import adc_stream_pkg::*;
    import acq_ctrl_pkg::*;
();

    localparam int RESET_CYCLES = 16;
    localparam int BG_SPAN = 300;
    localparam int HOT_MARGIN = 50;
    localparam int TAIL_BEATS = POST_BEATS + 8;
    localparam int EVENT_GAP = 60;
    localparam int DROP_EVENTS = 7;
    localparam int STATE_LIMIT = 40;
    localparam int DRAIN_LIMIT = 1200;

    // cycle budget of each test, drain included
    localparam int CYC_CALIB = 1 + STATE_LIMIT;
    localparam int CYC_SINGLE = 6 + TAIL_BEATS + DRAIN_LIMIT;
    localparam int CYC_MERGED = 11 + TAIL_BEATS + DRAIN_LIMIT;
    localparam int CYC_LONG = 80 + TAIL_BEATS + DRAIN_LIMIT;
    localparam int CYC_DROP = DROP_EVENTS * EVENT_GAP + DRAIN_LIMIT;
    localparam int CYC_IDLE = 100 + STATE_LIMIT + DRAIN_LIMIT;
    localparam int WATCHDOG_LIMIT = RESET_CYCLES + CYC_CALIB + CYC_SINGLE + CYC_MERGED
                                  + CYC_LONG + CYC_DROP + CYC_IDLE + 2000;

    logic AXIS_ACLK;
    logic AXIS_ARESETN;
    logic run_start;
    logic run_stop;
    tdata_t s_axis_tdata;
    tdata_t m_axis_tdata;
    logic m_axis_tvalid;
    logic m_axis_tlast;
    logic m_axis_tready;
    exec_state_t exec_state;
    adc_code_t baseline;
    logic [15:0] dropped_events;

    integer seed;
    int err_count;
    int check_count;
    int test_count;
    int test_err_start;
    int cycle_count;
    bit stall;

    // reference model of the run controller and the event rules
    exec_state_t m_state;
    exec_state_t m_next;
    int cal_n;
    int cal_sum;
    int m_base;
    int run_idx;
    bit ev_active;
    bit ev_admit;
    int ev_first;
    int ev_last;
    int exp_written;
    int popped;
    int exp_dropped;
    tdata_t exp_data[$];
    bit exp_last[$];
    tdata_t rx_trailer;

    mm_acq_top i_dut (
        .AXIS_ACLK      (AXIS_ACLK),
        .AXIS_ARESETN   (AXIS_ARESETN),
        .run_start      (run_start),
        .run_stop       (run_stop),
        .s_axis_tdata   (s_axis_tdata),
        .m_axis_tdata   (m_axis_tdata),
        .m_axis_tvalid  (m_axis_tvalid),
        .m_axis_tlast   (m_axis_tlast),
        .m_axis_tready  (m_axis_tready),
        .exec_state     (exec_state),
        .baseline       (baseline),
        .dropped_events (dropped_events)
    );

    initial
    begin
        AXIS_ACLK = 1'b0;
        forever
        begin
            #5 AXIS_ACLK = ~AXIS_ACLK;
        end
    end

    task automatic check_value(string name, logic [TDATA_W-1:0] got,
                               logic [TDATA_W-1:0] exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("ERR t=%0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    function automatic tdata_t flat_beat(int code);
        tdata_t beat;
        beat = '0;
        for (int i = 0; i < SAMPLES_PER_BEAT; i++)
            beat[i*LANE_W +: LANE_W] = LANE_W'(code);
        return beat;
    endfunction

    // every lane between baseline and baseline + BG_SPAN
    function automatic tdata_t bg_beat();
        tdata_t beat;
        beat = '0;
        for (int i = 0; i < SAMPLES_PER_BEAT; i++)
            beat[i*LANE_W +: LANE_W] = LANE_W'(m_base + ($unsigned($random(seed)) % (BG_SPAN + 1)));
        return beat;
    endfunction

    function automatic tdata_t hot_beat(int lane);
        tdata_t beat;
        beat = bg_beat();
        beat[lane*LANE_W +: LANE_W] = LANE_W'(m_base + THRESHOLD_VAL + HOT_MARGIN);
        return beat;
    endfunction

    // a lane crosses when it exceeds the baseline by at least the threshold
    function automatic bit crosses(tdata_t beat);
        int code;
        for (int i = 0; i < SAMPLES_PER_BEAT; i++)
        begin
            code = int'(beat[i*LANE_W +: ADC_BITS]);
            if (code - m_base >= THRESHOLD_VAL)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic open_event();
        ev_active = 1'b1;
        ev_first = run_idx;
        ev_admit = (FIFO_DEPTH - (exp_written - popped)) >= FRAME_ROOM;
        if (!ev_admit)
            exp_dropped++;
    endtask

    // data beats are already queued, only the trailer is left
    task automatic close_event();
        int full;
        int n;
        tdata_t trailer;
        full = ev_last - ev_first + 1 + POST_BEATS;
        n = (full > MAX_FRAME_BEATS) ? MAX_FRAME_BEATS : full;
        ev_active = 1'b0;
        if (ev_admit)
        begin
            trailer = '0;
            trailer[15:0] = 16'(ev_last + 1);
            trailer[31:16] = 16'(n);
            trailer[32] = full > MAX_FRAME_BEATS;
            exp_data.push_back(trailer);
            exp_last.push_back(1'b1);
            exp_written++;
        end
    endtask

    task automatic run_beat(tdata_t data);
        // one past the last data beat can still restart the window
        if (ev_active && run_idx > ev_last + POST_BEATS + 1)
            close_event();
        if (crosses(data))
        begin
            if (!ev_active)
                open_event();
            ev_last = run_idx;
        end
        // data beats leave the FIFO before the event closes
        if (ev_active && ev_admit && run_idx <= ev_last + POST_BEATS
            && run_idx - ev_first < MAX_FRAME_BEATS)
        begin
            exp_data.push_back(data);
            exp_last.push_back(1'b0);
            exp_written++;
        end
        run_idx++;
    endtask

    task automatic model_cycle(tdata_t data, bit start, bit stop);
        m_next = m_state;
        case (m_state)
            IDLE:
            begin
                if (start)
                begin
                    m_next = CALIB;
                    cal_n = 0;
                    cal_sum = 0;
                end
            end
            CALIB:
            begin
                if (stop)
                    m_next = IDLE;
                else if (cal_n == CALIB_BEATS)
                begin
                    // calib_done cycle, RUN follows
                    m_next = RUN;
                    run_idx = 0;
                    ev_active = 1'b0;
                end
                else
                begin
                    for (int i = 0; i < SAMPLES_PER_BEAT; i++)
                        cal_sum += int'(data[i*LANE_W +: ADC_BITS]);
                    cal_n++;
                    if (cal_n == CALIB_BEATS)
                        m_base = cal_sum / (CALIB_BEATS * SAMPLES_PER_BEAT);
                end
            end
            default:
            begin
                run_beat(data);
                if (stop)
                    m_next = IDLE;
            end
        endcase
    endtask

    // one clock: drive the beat, controls and tready, then update the model
    task automatic step(tdata_t data, bit start, bit stop);
        @(posedge AXIS_ACLK);
        #1;
        m_state = m_next;
        check_value("exec_state", exec_state, m_state);
        s_axis_tdata = data;
        run_start = start;
        run_stop = stop;
        m_axis_tready = stall ? 1'b0 : 1'($random(seed));
        model_cycle(data, start, stop);
    endtask

    task automatic background(int n);
        repeat (n)
            step(bg_beat(), 1'b0, 1'b0);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_data.size() != 0 && n < DRAIN_LIMIT)
        begin
            step(bg_beat(), 1'b0, 1'b0);
            n++;
        end
        if (exp_data.size() != 0)
        begin
            err_count++;
            $display("failure at %0t: %0d expected output beats never arrived",
                     $time, exp_data.size());
        end
    endtask

    task automatic wait_run();
        int n;
        n = 0;
        while (exec_state != RUN && n < STATE_LIMIT)
        begin
            step(bg_beat(), 1'b0, 1'b0);
            n++;
        end
        if (exec_state != RUN)
        begin
            err_count++;
            $display("failure at %0t: exec_state never reached RUN", $time);
        end
    endtask

    task automatic check_trailer(int stamp, int count, bit trunc);
        check_value("trailer stamp", rx_trailer[15:0], 16'(stamp));
        check_value("trailer count", rx_trailer[31:16], 16'(count));
        check_value("trailer trunc", rx_trailer[32], trunc);
    endtask

    task automatic finish_test(string name);
        test_count++;
        $display("test %-10s done, %0d errors", name, err_count - test_err_start);
        test_err_start = err_count;
    endtask

    task automatic calibrate_flat();
        int n;
        step(flat_beat(1000), 1'b1, 1'b0);
        n = 0;
        while (exec_state != RUN && n < STATE_LIMIT)
        begin
            step(flat_beat(1000), 1'b0, 1'b0);
            n++;
        end
        if (exec_state != RUN)
        begin
            err_count++;
            $display("failure at %0t: exec_state never reached RUN after calibration", $time);
        end
        check_value("baseline", baseline, 1000);
        finish_test("calib");
    endtask

    task automatic single_event();
        int k;
        background(5);
        k = run_idx;
        step(hot_beat(3), 1'b0, 1'b0);
        background(TAIL_BEATS);
        wait_drain();
        check_trailer(k + 1, 1 + POST_BEATS, 1'b0);
        finish_test("single");
    endtask

    task automatic merged_event();
        int a;
        int b;
        a = run_idx;
        step(hot_beat(0), 1'b0, 1'b0);
        background(9);
        b = run_idx;
        step(hot_beat(6), 1'b0, 1'b0);
        background(TAIL_BEATS);
        wait_drain();
        check_trailer(b + 1, b - a + 1 + POST_BEATS, 1'b0);
        finish_test("merged");
    endtask

    task automatic long_event();
        int last;
        repeat (80)
            step(hot_beat(7), 1'b0, 1'b0);
        last = run_idx - 1;
        background(TAIL_BEATS);
        wait_drain();
        check_trailer(last + 1, MAX_FRAME_BEATS, 1'b1);
        finish_test("long");
    endtask

    task automatic overflow_drop();
        stall = 1'b1;
        repeat (DROP_EVENTS)
        begin
            step(hot_beat(5), 1'b0, 1'b0);
            background(EVENT_GAP - 1);
        end
        // drops are counted while the output is still stalled
        check_value("dropped_events", dropped_events, exp_dropped);
        stall = 1'b0;
        wait_drain();
        check_value("dropped_events", dropped_events, exp_dropped);
        finish_test("drop");
    endtask

    task automatic idle_quiet();
        int rx_before;
        step(bg_beat(), 1'b0, 1'b1);
        repeat (20)
            step(hot_beat(1), 1'b0, 1'b0);
        step(bg_beat(), 1'b1, 1'b0);
        // hot beats inside calibration, the last one in the calib_done cycle
        for (int i = 0; i <= CALIB_BEATS; i++)
            step((i == 3 || i == 4 || i == CALIB_BEATS) ? hot_beat(2) : bg_beat(), 1'b0, 1'b0);
        wait_run();
        check_value("baseline", baseline, m_base);
        background(20);
        step(bg_beat(), 1'b0, 1'b1);
        rx_before = popped;
        repeat (40)
            step(hot_beat(4), 1'b0, 1'b0);
        wait_drain();
        check_value("output beats after stop", popped, rx_before);
        finish_test("idle");
    endtask

    // output monitor, values are stable at the edge that takes them
    always @(posedge AXIS_ACLK)
    begin
        if (AXIS_ARESETN && m_axis_tvalid && m_axis_tready)
        begin
            popped++;
            if (exp_data.size() == 0)
            begin
                err_count++;
                $display("failure at %0t: output beat arrived while no frame was expected",
                         $time);
            end
            else
            begin
                check_value("m_axis_tdata", m_axis_tdata, exp_data.pop_front());
                check_value("m_axis_tlast", m_axis_tlast, exp_last.pop_front());
            end
            if (m_axis_tlast)
                rx_trailer = m_axis_tdata;
        end
    end

    always @(posedge AXIS_ACLK)
    begin
        cycle_count++;
        if (cycle_count >= WATCHDOG_LIMIT)
        begin
            $display("watchdog: run exceeded %0d cycles", WATCHDOG_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial
    begin
        seed = 32'h81fd_23d0;
        AXIS_ARESETN = 1'b0;
        run_start = 1'b0;
        run_stop = 1'b0;
        s_axis_tdata = '0;
        m_axis_tready = 1'b0;
        stall = 1'b0;
        m_state = IDLE;
        m_next = IDLE;
        m_base = 0;
        ev_active = 1'b0;
        rx_trailer = '0;
        repeat (RESET_CYCLES) @(posedge AXIS_ACLK);
        #1;
        AXIS_ARESETN = 1'b1;
        calibrate_flat();
        single_event();
        merged_event();
        long_event();
        overflow_drop();
        idle_quiet();
        $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: mm_acq_top.f
src/adc_stream_pkg.sv
src/acq_ctrl_pkg.sv
src/exec_controller.sv
src/baseline_calib.sv
src/mm_trigger.sv
src/event_framer.sv
src/stream_fifo.sv
src/mm_acq_top.sv
dv/mm_acq_props.sv
dv/mm_acq_tb.sv

// File: src/acq_ctrl_pkg.sv
`default_nettype none

package acq_ctrl_pkg;

    import adc_stream_pkg::*;

    // run controller states
    typedef enum logic [1:0] {IDLE, CALIB, RUN} exec_state_t;

    // how the trigger sees the last registered beat
    typedef enum logic [1:0] {ZONE_BELOW, ZONE_ABOVE, ZONE_CALIB} trg_zone_t;

    typedef logic [15:0] time_stamp_t;
    typedef logic [15:0] beat_count_t;

    // threshold as a share of full scale
    localparam int THRESHOLD_PCT = 10;
    localparam int THRESHOLD_VAL = (1 << ADC_BITS) * THRESHOLD_PCT / 100;

    // 16 beats of 8 lanes, so the mean is a shift by 7
    localparam int CALIB_BEATS = 16;
    localparam int CALIB_CNT_W = $clog2(CALIB_BEATS);
    localparam int CALIB_SHIFT = $clog2(CALIB_BEATS * SAMPLES_PER_BEAT);
    localparam int CALIB_ACC_W = ADC_BITS + CALIB_SHIFT;

    // trailing window after the last crossing beat
    localparam int POST_BEATS = 38;
    localparam int POST_CNT_W = $clog2(POST_BEATS + 1);

    // data cap per frame, plus one beat for the trailer
    localparam int MAX_FRAME_BEATS = 64;
    localparam int FRAME_ROOM = MAX_FRAME_BEATS + 1;

endpackage

`default_nettype wire

// File: src/adc_stream_pkg.sv
`default_nettype none

package adc_stream_pkg;

    // converter stream, one beat per clock
    localparam int TDATA_W = 128;

    // lane pitch and code width inside each lane
    localparam int LANE_W = 16;
    localparam int ADC_BITS = 12;

    // lanes per beat
    localparam int SAMPLES_PER_BEAT = TDATA_W / LANE_W;

    // output buffer, in beats
    localparam int FIFO_DEPTH = 256;

    // free-space count has to reach FIFO_DEPTH itself
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // one full beat of eight lanes
    typedef logic [TDATA_W-1:0] tdata_t;

    // unsigned sample code, taken from the low bits of a lane
    typedef logic [ADC_BITS-1:0] adc_code_t;

endpackage

`default_nettype wire

// File: src/baseline_calib.sv
`default_nettype none

module baseline_calib
    import adc_stream_pkg::*;
    import acq_ctrl_pkg::*;
(
    input  wire         AXIS_ACLK,
    input  wire         AXIS_ARESETN,
    input  wire         exec_state_t exec_state,
    input  wire         tdata_t s_axis_tdata,
    output adc_code_t   baseline,
    output logic        calib_done
);

    logic [CALIB_ACC_W-1:0] beat_sum;
    logic [CALIB_ACC_W-1:0] acc;
    logic [CALIB_ACC_W-1:0] acc_next;
    logic [CALIB_CNT_W-1:0] beat_cnt;

    // sum of the eight lane codes of this beat
    always_comb
    begin
        beat_sum = '0;
        for (int i = 0; i < SAMPLES_PER_BEAT; i++)
        begin
            beat_sum = beat_sum + s_axis_tdata[i*LANE_W +: ADC_BITS];
        end
        acc_next = acc + beat_sum;
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            acc <= '0;
            beat_cnt <= '0;
            baseline <= '0;
            calib_done <= 1'b0;
        end
        else
        begin
            calib_done <= 1'b0;
            // hold off once done, the controller leaves CALIB a cycle later
            if (exec_state != CALIB || calib_done)
            begin
                acc <= '0;
                beat_cnt <= '0;
            end
            else
            begin
                acc <= acc_next;
                beat_cnt <= beat_cnt + 1'b1;
                if (beat_cnt == CALIB_CNT_W'(CALIB_BEATS - 1))
                begin
                    // mean over all samples is the top bits of the sum
                    baseline <= acc_next[CALIB_ACC_W-1 -: ADC_BITS];
                    calib_done <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/event_framer.sv
`default_nettype none

module event_framer
    import adc_stream_pkg::*;
    import acq_ctrl_pkg::*;
(
    input  wire                  AXIS_ACLK,
    input  wire                  AXIS_ARESETN,
    input  wire                  tdata_t s_axis_tdata,
    input  wire                  start_trg,
    input  wire                  finalize_trg,
    input  wire                  time_stamp_t time_stamp,
    input  wire [FIFO_CNT_W-1:0] fifo_free,
    output logic                 wr_en,
    output tdata_t               wr_data,
    output logic                 wr_last,
    output logic [15:0]          dropped_events
);

    tdata_t data_d1;
    tdata_t data_d2;
    tdata_t trailer;
    logic start_q;
    logic in_frame;
    logic trunc;
    beat_count_t beat_cnt;
    logic [POST_CNT_W-1:0] post_seen;
    logic rise;
    logic fall;
    logic room_ok;

    // two beats of delay line the trigger up with its data
    always_ff @(posedge AXIS_ACLK)
    begin
        data_d1 <= s_axis_tdata;
        data_d2 <= data_d1;
    end

    always_comb
    begin
        rise = start_trg && !start_q;
        fall = !start_trg && start_q;
        room_ok = fifo_free >= FIFO_CNT_W'(FRAME_ROOM);
        trailer = '0;
        trailer[15:0] = time_stamp;
        trailer[31:16] = beat_cnt;
        // capped data or a post window cut short by run stop
        trailer[32] = trunc || (post_seen != POST_CNT_W'(POST_BEATS));
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            start_q <= 1'b0;
            in_frame <= 1'b0;
            trunc <= 1'b0;
            beat_cnt <= '0;
            post_seen <= '0;
            dropped_events <= '0;
        end
        else
        begin
            start_q <= start_trg;
            if (rise)
            begin
                trunc <= 1'b0;
                post_seen <= '0;
                if (room_ok)
                begin
                    in_frame <= 1'b1;
                    beat_cnt <= beat_count_t'(1);
                end
                else
                begin
                    in_frame <= 1'b0;
                    if (dropped_events != 16'hffff)
                        dropped_events <= dropped_events + 1'b1;
                end
            end
            else if (start_trg && in_frame)
            begin
                if (beat_cnt < beat_count_t'(MAX_FRAME_BEATS))
                    beat_cnt <= beat_cnt + 1'b1;
                else
                    trunc <= 1'b1;
                // length of the current uninterrupted post window
                if (finalize_trg)
                    post_seen <= post_seen + 1'b1;
                else
                    post_seen <= '0;
            end
            else if (fall)
            begin
                in_frame <= 1'b0;
            end
        end
    end

    // data beats while the trigger is high, trailer in the first low cycle
    always_comb
    begin
        wr_en = 1'b0;
        wr_data = data_d2;
        wr_last = 1'b0;
        if (rise)
        begin
            wr_en = room_ok;
        end
        else if (start_trg && in_frame)
        begin
            wr_en = beat_cnt < beat_count_t'(MAX_FRAME_BEATS);
        end
        else if (fall && in_frame)
        begin
            wr_en = 1'b1;
            wr_data = trailer;
            wr_last = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/exec_controller.sv
`default_nettype none

module exec_controller
    import acq_ctrl_pkg::*;
(
    input  wire         AXIS_ACLK,
    input  wire         AXIS_ARESETN,
    input  wire         run_start,
    input  wire         run_stop,
    input  wire         calib_done,
    output exec_state_t exec_state,
    output time_stamp_t current_time
);

    exec_state_t state_next;

    // run_stop wins over calib_done
    always_comb
    begin
        state_next = exec_state;
        case (exec_state)
            IDLE:
            begin
                if (run_start)
                    state_next = CALIB;
            end
            CALIB:
            begin
                if (run_stop)
                    state_next = IDLE;
                else if (calib_done)
                    state_next = RUN;
            end
            RUN:
            begin
                if (run_stop)
                    state_next = IDLE;
            end
            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            exec_state <= IDLE;
            current_time <= '0;
        end
        else
        begin
            exec_state <= state_next;
            // zero in the first RUN cycle, frozen outside RUN
            if (state_next == RUN && exec_state != RUN)
                current_time <= '0;
            else if (exec_state == RUN)
                current_time <= current_time + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/mm_acq_top.sv
`default_nettype none

module mm_acq_top
    import adc_stream_pkg::*;
    import acq_ctrl_pkg::*;
(
    input  wire         AXIS_ACLK,
    input  wire         AXIS_ARESETN,
    input  wire         run_start,
    input  wire         run_stop,
    input  wire         tdata_t s_axis_tdata,
    output tdata_t      m_axis_tdata,
    output logic        m_axis_tvalid,
    output logic        m_axis_tlast,
    input  wire         m_axis_tready,
    output exec_state_t exec_state,
    output adc_code_t   baseline,
    output logic [15:0] dropped_events
);

    time_stamp_t current_time;
    time_stamp_t time_stamp;
    logic calib_done;
    logic start_trg;
    logic finalize_trg;
    logic wr_en;
    tdata_t wr_data;
    logic wr_last;
    logic [FIFO_CNT_W-1:0] fifo_free;

    exec_controller i_exec_controller (
        .AXIS_ACLK      (AXIS_ACLK),
        .AXIS_ARESETN   (AXIS_ARESETN),
        .run_start      (run_start),
        .run_stop       (run_stop),
        .calib_done     (calib_done),
        .exec_state     (exec_state),
        .current_time   (current_time)
    );

    baseline_calib i_baseline_calib (
        .AXIS_ACLK      (AXIS_ACLK),
        .AXIS_ARESETN   (AXIS_ARESETN),
        .exec_state     (exec_state),
        .s_axis_tdata   (s_axis_tdata),
        .baseline       (baseline),
        .calib_done     (calib_done)
    );

    mm_trigger i_mm_trigger (
        .AXIS_ACLK      (AXIS_ACLK),
        .AXIS_ARESETN   (AXIS_ARESETN),
        .exec_state     (exec_state),
        .baseline       (baseline),
        .current_time   (current_time),
        .s_axis_tdata   (s_axis_tdata),
        .start_trg      (start_trg),
        .finalize_trg   (finalize_trg),
        .time_stamp     (time_stamp)
    );

    event_framer i_event_framer (
        .AXIS_ACLK      (AXIS_ACLK),
        .AXIS_ARESETN   (AXIS_ARESETN),
        .s_axis_tdata   (s_axis_tdata),
        .start_trg      (start_trg),
        .finalize_trg   (finalize_trg),
        .time_stamp     (time_stamp),
        .fifo_free      (fifo_free),
        .wr_en          (wr_en),
        .wr_data        (wr_data),
        .wr_last        (wr_last),
        .dropped_events (dropped_events)
    );

    stream_fifo i_stream_fifo (
        .AXIS_ACLK      (AXIS_ACLK),
        .AXIS_ARESETN   (AXIS_ARESETN),
        .wr_en          (wr_en),
        .wr_data        (wr_data),
        .wr_last        (wr_last),
        .fifo_free      (fifo_free),
        .m_axis_tdata   (m_axis_tdata),
        .m_axis_tvalid  (m_axis_tvalid),
        .m_axis_tlast   (m_axis_tlast),
        .m_axis_tready  (m_axis_tready)
    );

endmodule

`default_nettype wire

// File: src/mm_trigger.sv
`default_nettype none

module mm_trigger
    import adc_stream_pkg::*;
    import acq_ctrl_pkg::*;
(
    input  wire         AXIS_ACLK,
    input  wire         AXIS_ARESETN,
    input  wire         exec_state_t exec_state,
    input  wire         adc_code_t baseline,
    input  wire         time_stamp_t current_time,
    input  wire         tdata_t s_axis_tdata,
    output logic        start_trg,
    output logic        finalize_trg,
    output time_stamp_t time_stamp
);

    trg_zone_t zone;
    trg_zone_t zone_d;
    logic [ADC_BITS:0] level;
    logic crossing;
    logic start_q;
    logic finalize_q;
    logic [POST_CNT_W-1:0] post_cnt;

    // one extra bit so baseline plus threshold cannot wrap
    always_comb
    begin
        level = {1'b0, baseline} + THRESHOLD_VAL[ADC_BITS:0];
        crossing = 1'b0;
        for (int i = 0; i < SAMPLES_PER_BEAT; i++)
        begin
            if ({1'b0, s_axis_tdata[i*LANE_W +: ADC_BITS]} >= level)
                crossing = 1'b1;
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            zone <= ZONE_CALIB;
            zone_d <= ZONE_CALIB;
        end
        else
        begin
            zone_d <= zone;
            if (exec_state != RUN)
                zone <= ZONE_CALIB;
            else if (crossing)
                zone <= ZONE_ABOVE;
            else
                zone <= ZONE_BELOW;
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN || exec_state != RUN)
        begin
            start_q <= 1'b0;
            finalize_q <= 1'b0;
            post_cnt <= '0;
        end
        else if (zone == ZONE_ABOVE)
        begin
            // a crossing restarts the post window
            start_q <= 1'b1;
            finalize_q <= 1'b0;
            post_cnt <= '0;
        end
        else if (zone_d == ZONE_ABOVE)
        begin
            start_q <= 1'b1;
            finalize_q <= 1'b1;
            post_cnt <= POST_CNT_W'(1);
        end
        else if (finalize_q && post_cnt < POST_CNT_W'(POST_BEATS))
        begin
            start_q <= 1'b1;
            finalize_q <= 1'b1;
            post_cnt <= post_cnt + 1'b1;
        end
        else
        begin
            start_q <= 1'b0;
            finalize_q <= 1'b0;
            post_cnt <= '0;
        end
    end

    // stamp of the latest crossing beat
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
            time_stamp <= '0;
        else if (zone == ZONE_ABOVE)
            time_stamp <= current_time;
    end

    // a run stop closes the event at once
    assign start_trg = start_q && (exec_state == RUN);
    assign finalize_trg = finalize_q && (exec_state == RUN);

endmodule

`default_nettype wire

// File: src/stream_fifo.sv
`default_nettype none

module stream_fifo
    import adc_stream_pkg::*;
#(
    parameter int WIDTH = TDATA_W,
    parameter int DEPTH = FIFO_DEPTH
)
(
    input  wire                         AXIS_ACLK,
    input  wire                         AXIS_ARESETN,
    input  wire                         wr_en,
    input  wire [WIDTH-1:0]             wr_data,
    input  wire                         wr_last,
    output logic [$clog2(DEPTH+1)-1:0]  fifo_free,
    output logic [WIDTH-1:0]            m_axis_tdata,
    output logic                        m_axis_tvalid,
    output logic                        m_axis_tlast,
    input  wire                         m_axis_tready
);

    // last flag rides in the top bit
    logic [WIDTH:0] mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic do_wr;
    logic do_rd;

    assign do_wr = wr_en && (count != DEPTH[$clog2(DEPTH+1)-1:0]);
    assign do_rd = m_axis_tvalid && m_axis_tready;

    always_ff @(posedge AXIS_ACLK)
    begin
        if (do_wr)
            mem[wr_ptr] <= {wr_last, wr_data};
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

    // head entry shows without a read request
    assign m_axis_tvalid = count != '0;
    assign {m_axis_tlast, m_axis_tdata} = mem[rd_ptr];
    assign fifo_free = DEPTH[$clog2(DEPTH+1)-1:0] - count;

endmodule

`default_nettype wire
